// ==== src/ahb_burst_pkg.sv ====
`default_nettype none

package ahb_burst_pkg;

    // AHB hburst encoding. Only SINGLE, INCR4 and WRAP4 are issued here.
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } burst_t;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } trans_t;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_BURST     = 2'd1,
        ST_LAST_DATA = 2'd2
    } master_state_t;

    localparam logic [31:0] WRAP4_MASK = 32'hFFFF_FFF0; // 16-byte wrap block.
    localparam int unsigned BEAT_BYTES = 4;

endpackage

`default_nettype wire

// ==== src/burst_addr_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_addr_gen
    import ahb_burst_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              start,
    input  wire logic [ADDR_W-1:0] start_addr,
    input  wire burst_t            burst,
    input  wire logic              advance,
    output logic      [ADDR_W-1:0] beat_addr,
    output logic                   last_beat
);

    localparam logic [ADDR_W-1:0] BLOCK_MASK = ADDR_W'(WRAP4_MASK);
    localparam logic [ADDR_W-1:0] STEP       = ADDR_W'(BEAT_BYTES);

    logic [ADDR_W-1:0] base_q;
    logic [ADDR_W-1:0] offset_q;
    logic [ADDR_W-1:0] offset_step;
    logic [1:0]        cnt_q;
    burst_t            burst_q;

    // WRAP4 keeps the offset inside the block, the other bursts count straight up.
    always_comb begin
        if (burst_q == WRAP4) begin
            offset_step = (offset_q + STEP) & ~BLOCK_MASK;
        end else begin
            offset_step = offset_q + STEP;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            base_q   <= '0;
            offset_q <= '0;
            cnt_q    <= 2'd0;
            burst_q  <= SINGLE;
        end else if (start) begin
            burst_q <= burst;
            cnt_q   <= 2'd0;
            if (burst == WRAP4) begin
                base_q   <= start_addr & BLOCK_MASK; // Block base.
                offset_q <= start_addr & ~BLOCK_MASK;
            end else begin
                base_q   <= start_addr;
                offset_q <= '0;
            end
        end else if (advance) begin
            offset_q <= offset_step;
            cnt_q    <= cnt_q + 2'd1;
        end
    end

    assign beat_addr = base_q + offset_q;
    assign last_beat = (burst_q == SINGLE) || (cnt_q == 2'd3);

    // A wrapping burst never leaves the block its first beat was in.
    assert property (@(posedge clk) disable iff (!rstn)
        (burst_q == WRAP4 && advance && !last_beat && !start)
        |=> ((beat_addr & BLOCK_MASK) == ($past(beat_addr) & BLOCK_MASK)))
        else $error("WRAP4 beat address left its 16-byte block");

endmodule

`default_nettype wire

// ==== src/ahb_master_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module ahb_master_ctrl
    import ahb_burst_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              cmd_valid,
    input  wire logic              cmd_write,
    input  wire burst_t            cmd_burst,
    input  wire logic [ADDR_W-1:0] cmd_addr,
    output logic                   cmd_ready,
    input  wire logic [31:0]       wdata,
    output logic                   wdata_ready,
    output logic                   rdata_valid,
    output logic      [ADDR_W-1:0] read_addr,
    output logic      [31:0]       read_data,
    output logic                   start,
    output logic      [ADDR_W-1:0] start_addr,
    output burst_t                 burst,
    output logic                   advance,
    input  wire logic [ADDR_W-1:0] beat_addr,
    input  wire logic              last_beat,
    output logic      [ADDR_W-1:0] haddr,
    output trans_t                 htrans,
    output burst_t                 hburst,
    output logic                   hwrite,
    output logic      [31:0]       hwdata,
    input  wire logic [31:0]       hrdata,
    input  wire logic              hready
);

    master_state_t     state_q;
    master_state_t     state_d;
    logic              first_q;
    logic              write_q;
    burst_t            burst_q;
    logic              dp_valid_q;
    logic              dp_write_q;
    logic [ADDR_W-1:0] dp_addr_q;
    logic              read_done;

    assign cmd_ready  = (state_q == ST_IDLE);
    assign start      = cmd_valid && cmd_ready;
    assign start_addr = cmd_addr;
    assign burst      = cmd_burst;

    always_comb begin
        if (state_q == ST_BURST) begin
            htrans = first_q ? NONSEQ : SEQ;
        end else begin
            htrans = IDLE;
        end
    end

    assign haddr   = beat_addr; // Generator only steps on an accepted phase.
    assign hburst  = burst_q;
    assign hwrite  = write_q;
    assign advance = (htrans != IDLE) && hready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cmd_valid) begin
                    state_d = ST_BURST;
                end
            end
            ST_BURST: begin
                if (hready && last_beat) begin
                    state_d = ST_LAST_DATA;
                end
            end
            ST_LAST_DATA: begin
                if (hready) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= ST_IDLE;
            first_q <= 1'b0;
            write_q <= 1'b0;
            burst_q <= SINGLE;
        end else begin
            state_q <= state_d;
            if (start) begin
                first_q <= 1'b1;
                write_q <= cmd_write;
                burst_q <= cmd_burst;
            end else if (advance) begin
                first_q <= 1'b0;
            end
        end
    end

    // Data phase copy of the accepted address phase.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dp_valid_q <= 1'b0;
            dp_write_q <= 1'b0;
        end else if (hready) begin
            dp_valid_q <= (htrans != IDLE);
            dp_write_q <= hwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (hready) begin
            dp_addr_q <= haddr;
        end
    end

    assign wdata_ready = dp_valid_q && dp_write_q && hready;
    assign hwdata      = (dp_valid_q && dp_write_q) ? wdata : '0;
    assign read_done   = dp_valid_q && !dp_write_q && hready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= read_done;
        end
    end

    always_ff @(posedge clk) begin
        if (read_done) begin
            read_addr <= dp_addr_q;
            read_data <= hrdata;
        end
    end

    // A waited address phase must not change under the slave.
    assert property (@(posedge clk) disable iff (!rstn)
        (htrans != IDLE && !hready) |=> ($stable(haddr) && $stable(htrans)))
        else $error("Address phase changed while hready was low");

endmodule

`default_nettype wire

// ==== src/ahb_sram_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module ahb_sram_slave
    import ahb_burst_pkg::*;
#(
    parameter int ADDR_W    = 32,
    parameter int MEM_WORDS = 64
) (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic [ADDR_W-1:0] haddr,
    input  wire trans_t            htrans,
    input  wire logic              hwrite,
    input  wire logic [31:0]       hwdata,
    output logic      [31:0]       hrdata,
    output logic                   hready,
    input  wire logic              stall
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0]      mem [MEM_WORDS];
    logic             dp_active_q;
    logic             dp_write_q;
    logic [IDX_W-1:0] dp_idx_q;
    logic             last_idle_q;

    // Wait states only exist inside a data phase.
    assign hready = dp_active_q ? !stall : 1'b1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dp_active_q <= 1'b0;
            dp_write_q  <= 1'b0;
            dp_idx_q    <= '0;
            last_idle_q <= 1'b1;
        end else if (hready) begin
            dp_active_q <= (htrans == NONSEQ) || (htrans == SEQ);
            dp_write_q  <= hwrite;
            dp_idx_q    <= haddr[IDX_W+1:2]; // Word index wraps at the depth.
            last_idle_q <= (htrans == IDLE);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (dp_active_q && dp_write_q && hready) begin
            mem[dp_idx_q] <= hwdata;
        end
    end

    assign hrdata = mem[dp_idx_q];

    // Bursts always open with NONSEQ.
    assert property (@(posedge clk) disable iff (!rstn)
        (hready && htrans == SEQ) |-> !last_idle_q)
        else $error("SEQ accepted right after an IDLE address phase");

endmodule

`default_nettype wire

// ==== src/ahb_burst_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ahb_burst_top
    import ahb_burst_pkg::*;
#(
    parameter int ADDR_W    = 32,
    parameter int MEM_WORDS = 64
) (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              cmd_valid,
    input  wire logic              cmd_write,
    input  wire burst_t            cmd_burst,
    input  wire logic [ADDR_W-1:0] cmd_addr,
    output logic                   cmd_ready,
    input  wire logic [31:0]       wdata,
    output logic                   wdata_ready,
    output logic                   rdata_valid,
    output logic      [ADDR_W-1:0] read_addr,
    output logic      [31:0]       read_data,
    input  wire logic              stall
);

    logic              start;
    logic [ADDR_W-1:0] start_addr;
    burst_t            burst;
    logic              advance;
    logic [ADDR_W-1:0] beat_addr;
    logic              last_beat;
    logic [ADDR_W-1:0] haddr;
    trans_t            htrans;
    burst_t            hburst;
    logic              hwrite;
    logic [31:0]       hwdata;
    logic [31:0]       hrdata;
    logic              hready;

    ahb_master_ctrl #(
        .ADDR_W(ADDR_W)
    ) master (
        .clk         (clk),
        .rstn        (rstn),
        .cmd_valid   (cmd_valid),
        .cmd_write   (cmd_write),
        .cmd_burst   (cmd_burst),
        .cmd_addr    (cmd_addr),
        .cmd_ready   (cmd_ready),
        .wdata       (wdata),
        .wdata_ready (wdata_ready),
        .rdata_valid (rdata_valid),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .start       (start),
        .start_addr  (start_addr),
        .burst       (burst),
        .advance     (advance),
        .beat_addr   (beat_addr),
        .last_beat   (last_beat),
        .haddr       (haddr),
        .htrans      (htrans),
        .hburst      (hburst),
        .hwrite      (hwrite),
        .hwdata      (hwdata),
        .hrdata      (hrdata),
        .hready      (hready)
    );

    burst_addr_gen #(
        .ADDR_W(ADDR_W)
    ) addr_gen (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .start_addr (start_addr),
        .burst      (burst),
        .advance    (advance),
        .beat_addr  (beat_addr),
        .last_beat  (last_beat)
    );

    // The single slave sees no hburst, it follows htrans alone.
    ahb_sram_slave #(
        .ADDR_W    (ADDR_W),
        .MEM_WORDS (MEM_WORDS)
    ) sram (
        .clk    (clk),
        .rstn   (rstn),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hready (hready),
        .stall  (stall)
    );

    // hburst only matters to a bus monitor, checked here against the command type.
    assert property (@(posedge clk) disable iff (!rstn)
        (htrans == NONSEQ) |-> (hburst == SINGLE || hburst == INCR4 || hburst == WRAP4))
        else $error("Unsupported burst type on the bus");

endmodule

`default_nettype wire

// ==== dv/tb_ahb_burst.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ahb_burst
    import ahb_burst_pkg::*;
;

    localparam int MAX_VEC = 64;

    logic        clk;
    logic        rstn;
    logic        cmd_valid;
    logic        cmd_write;
    burst_t      cmd_burst;
    logic [31:0] cmd_addr;
    logic        cmd_ready;
    logic [31:0] wdata;
    logic        wdata_ready;
    logic        rdata_valid;
    logic [31:0] read_addr;
    logic [31:0] read_data;
    logic        stall;

    logic        v_op    [MAX_VEC];
    burst_t      v_burst [MAX_VEC];
    logic [31:0] v_addr  [MAX_VEC];
    logic [31:0] v_data  [MAX_VEC][4];
    logic [31:0] v_exp   [MAX_VEC][4];
    logic [31:0] model_mem [64];

    int    n_vec = 0;
    int    seed = 31;
    int    cycles = 0;
    int    limit = 100;
    int    errors = 0;
    int    checks = 0;
    int    runs = 0;
    logic  stall_mode = 1'b0;
    string test_name = "setup";

    ahb_burst_top #(
        .ADDR_W    (32),
        .MEM_WORDS (64)
    ) uut (
        .clk         (clk),
        .rstn        (rstn),
        .cmd_valid   (cmd_valid),
        .cmd_write   (cmd_write),
        .cmd_burst   (cmd_burst),
        .cmd_addr    (cmd_addr),
        .cmd_ready   (cmd_ready),
        .wdata       (wdata),
        .wdata_ready (wdata_ready),
        .rdata_valid (rdata_valid),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .stall       (stall)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the run hung in %s after %0d cycles", test_name, cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Beat address by the AHB rules with word steps and WRAP4 kept in its 16-byte block.
    function automatic logic [31:0] beat_address(input logic [31:0] start, input burst_t bt,
                                                 input int k);
        logic [31:0] step;
        step = k * 4;
        if (bt == WRAP4) begin
            beat_address = (start & 32'hFFFF_FFF0) | ((start + step) & 32'h0000_000F);
        end else begin
            beat_address = start + step;
        end
    endfunction

    function automatic int beat_count(input burst_t bt);
        beat_count = (bt == SINGLE) ? 1 : 4;
    endfunction

    function automatic string burst_name(input burst_t bt);
        case (bt)
            SINGLE:  burst_name = "SINGLE";
            INCR4:   burst_name = "INCR4";
            WRAP4:   burst_name = "WRAP4";
            default: burst_name = "OTHER";
        endcase
    endfunction

    function automatic logic next_stall();
        next_stall = stall_mode && (($random(seed) & 3) == 0); // About one cycle in four.
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            $display("CHECK FAILED %s %s: expected %08h actual %08h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("Error in %s: %s", test_name, msg);
            errors++;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] t [11];
        fd = $fopen("dv/ahb_burst_vectors.txt", "r");
        check_true(fd != 0, "the vector file could not be opened");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0 && n_vec < MAX_VEC) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", t[0], t[1], t[2],
                            t[3], t[4], t[5], t[6], t[7], t[8], t[9], t[10]);
                if (n == 11) begin
                    v_op[n_vec]    = t[0][0];
                    v_burst[n_vec] = burst_t'(t[1][2:0]);
                    v_addr[n_vec]  = t[2];
                    for (int j = 0; j < 4; j++) begin
                        v_data[n_vec][j] = t[3 + j];
                        v_exp[n_vec][j]  = t[7 + j];
                    end
                    n_vec++;
                end
            end
            $fclose(fd);
        end
        check_true(n_vec > 0, "no vectors were read");
    endtask

    task automatic apply_reset();
        int err_start;
        @(negedge clk);
        rstn      = 1'b0;
        cmd_valid = 1'b0;
        stall     = 1'b0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        test_name = stall_mode ? "reset_stall" : "reset";
        err_start = errors;
        check_true(cmd_ready, "cmd_ready is low after reset");
        check_true(!rdata_valid, "rdata_valid is high after reset");
        check_true(!wdata_ready, "wdata_ready is high after reset");
        $display("%s: outputs after reset, %s", test_name,
                 (errors == err_start) ? "ok" : "errors");
        for (int a = 0; a < 64; a++) begin
            model_mem[a] = '0;
        end
    endtask

    // Called on a falling edge before anything is driven in this cycle.
    task automatic run_command(input int i);
        int          n_beats;
        int          wi;
        int          ri;
        int          cyc;
        int          last_cyc;
        int          err_start;
        logic        done;
        logic [31:0] exp_addr;
        n_beats   = beat_count(v_burst[i]);
        wi        = 0;
        ri        = 0;
        cyc       = 0;
        last_cyc  = 0;
        done      = 1'b0;
        err_start = errors;
        cmd_valid = 1'b1;
        cmd_write = v_op[i];
        cmd_burst = v_burst[i];
        cmd_addr  = v_addr[i];
        wdata     = v_data[i][0];
        stall     = next_stall();
        while (!done) begin
            @(negedge clk);
            cyc++;
            if (rdata_valid) begin
                if (v_op[i] || ri >= n_beats) begin
                    check_true(1'b0, "an extra rdata_valid pulse arrived");
                end else begin
                    exp_addr = beat_address(v_addr[i], v_burst[i], ri);
                    if (ri == 0) begin
                        check_true(cyc >= 3, "the first read beat came too soon after accept");
                    end
                    check_value($sformatf("read_addr[%0d]", ri), exp_addr, read_addr);
                    check_value($sformatf("read_data[%0d]", ri), v_exp[i][ri], read_data);
                    check_value($sformatf("model[%0d]", ri), model_mem[exp_addr[7:2]],
                                read_data);
                end
                ri++;
                if (!v_op[i] && ri == n_beats) begin
                    last_cyc = cyc; // The last read result comes with cmd_ready.
                end
            end
            if (cyc == 1) begin
                check_true(!cmd_ready, "cmd_ready stayed high with a burst in flight");
            end
            if (cmd_ready) begin
                done = 1'b1;
            end else begin
                cmd_valid = 1'b0;
                stall     = next_stall();
                wdata     = v_data[i][(wi < 4) ? wi : 3];
                #1;
                if (wdata_ready) begin
                    if (!v_op[i] || wi >= n_beats) begin
                        check_true(1'b0, "wdata_ready rose outside a write beat");
                    end else begin
                        exp_addr = beat_address(v_addr[i], v_burst[i], wi);
                        model_mem[exp_addr[7:2]] = wdata;
                    end
                    wi++;
                    if (v_op[i] && wi == n_beats) begin
                        last_cyc = cyc + 1; // The command ends one cycle after the last write.
                    end
                end
            end
        end
        if (v_op[i]) begin
            check_value("write beats", n_beats, wi);
        end else begin
            check_value("read beats", n_beats, ri);
        end
        check_value("cmd_ready return cycle", last_cyc, cyc);
        $display("%s: %s %s at %08h, %0d beats, %s", test_name, v_op[i] ? "write" : "read",
                 burst_name(v_burst[i]), v_addr[i], v_op[i] ? wi : ri,
                 (errors == err_start) ? "ok" : "errors");
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_burst = SINGLE;
        cmd_addr  = '0;
        wdata     = '0;
        stall     = 1'b0;
        load_vectors();
        limit = 2 * n_vec * 40 + 100; // Two passes over the vectors.
        if (n_vec > 0) begin
            for (int pass = 0; pass < 2; pass++) begin
                stall_mode = (pass == 1);
                apply_reset(); // Memory starts from zero in both passes.
                for (int i = 0; i < n_vec; i++) begin
                    test_name = $sformatf("%s_%0d", stall_mode ? "stall" : "nostall", i);
                    run_command(i);
                    runs++;
                end
            end
        end
        $display("Commands run %0d, checks %0d, errors %0d", runs, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/ahb_burst_vectors.txt ====
// op (1 write, 0 read)  burst (0 SINGLE, 3 INCR4, 2 WRAP4)  start address
// then four write data words and four expected read words, all in hex
1 0 00000010 A5A50010 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0 0 00000010 00000000 00000000 00000000 00000000 A5A50010 00000000 00000000 00000000
1 3 00000020 11111111 22222222 33333333 44444444 00000000 00000000 00000000 00000000
0 3 00000020 00000000 00000000 00000000 00000000 11111111 22222222 33333333 44444444
// WRAP4 write from offset 8, read back from offset 4
1 2 00000048 C0DE0048 C0DE004C C0DE0040 C0DE0044 00000000 00000000 00000000 00000000
0 2 00000044 00000000 00000000 00000000 00000000 C0DE0044 C0DE0048 C0DE004C C0DE0040
0 0 00000030 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
1 3 00000050 DEADBEEF 01234567 89ABCDEF FEDCBA98 00000000 00000000 00000000 00000000
0 2 0000005C 00000000 00000000 00000000 00000000 FEDCBA98 DEADBEEF 01234567 89ABCDEF
1 0 00000024 55AA55AA 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0 3 00000020 00000000 00000000 00000000 00000000 11111111 55AA55AA 33333333 44444444
1 2 0000006C B000006C B0000060 B0000064 B0000068 00000000 00000000 00000000 00000000
0 3 00000060 00000000 00000000 00000000 00000000 B0000060 B0000064 B0000068 B000006C
0 2 00000040 00000000 00000000 00000000 00000000 C0DE0040 C0DE0044 C0DE0048 C0DE004C
// Top words of the slave
1 3 000000F0 0F0F0F0F F0F0F0F0 12345678 9ABCDEF0 00000000 00000000 00000000 00000000
0 3 000000F0 00000000 00000000 00000000 00000000 0F0F0F0F F0F0F0F0 12345678 9ABCDEF0
0 0 000000FC 00000000 00000000 00000000 00000000 9ABCDEF0 00000000 00000000 00000000
1 0 00000000 00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0 2 00000008 00000000 00000000 00000000 00000000 00000000 00000000 00000001 00000000
0 0 00000010 00000000 00000000 00000000 00000000 A5A50010 00000000 00000000 00000000

// ==== compile.f ====
src/ahb_burst_pkg.sv
src/burst_addr_gen.sv
src/ahb_master_ctrl.sv
src/ahb_sram_slave.sv
src/ahb_burst_top.sv
dv/tb_ahb_burst.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the AHB burst testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_ahb_burst --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_ahb_burst)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
